// ==== common/sched_cfg.svh ====
/* Sizes of the egress scheduler: ports, queues, FIFO depth, bus word and field widths */

`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// Egress ports and priority queues per port
`define SCHED_NUM_PORTS   4
`define SCHED_PRIOS       4
`define SCHED_NUM_QUEUES  16

// Widths of the queue number fields
`define SCHED_PORT_W      2
`define SCHED_PRIO_W      2
`define SCHED_QUEUE_W     4

// Descriptor FIFOs
`define SCHED_FIFO_DEPTH  8
`define SCHED_PTR_W       3
`define SCHED_CNT_W       4

// Packet lengths and bus words
`define SCHED_WORD_BYTES  64
`define SCHED_WORD_BYTES_W 7
`define SCHED_LEN_W       11
`define SCHED_LEN_LSB     16

// Wishbone data width
`define SCHED_WB_DW       32

`endif

// ==== common/sched_pkg.sv ====
/* Scheduler types: queue, port and priority numbers, lengths, masks, segmenter FSM */

`default_nettype none

`include "sched_cfg.svh"

package sched_pkg;

    // Queue number, port in the upper bits and priority in the lower bits
    typedef logic [`SCHED_QUEUE_W-1:0] queue_id_t;
    typedef logic [`SCHED_PORT_W-1:0]  port_id_t;
    typedef logic [`SCHED_PRIO_W-1:0]  prio_t;

    // Packet length in bytes
    typedef logic [`SCHED_LEN_W-1:0] pkt_len_t;

    // Bytes in one bus word, 1 to 64
    typedef logic [`SCHED_WORD_BYTES_W-1:0] word_bytes_t;

    // One bit per queue or per port
    typedef logic [`SCHED_NUM_QUEUES-1:0] queue_mask_t;
    typedef logic [`SCHED_NUM_PORTS-1:0]  port_mask_t;

    // Word segmenter FSM
    typedef enum logic {
        seg_idle,
        seg_send
    } seg_state_t;

endpackage

`default_nettype wire

// ==== rtl/enqueue_wb_slave.sv ====
/* Wishbone classic slave: descriptor enqueue writes and empty flag status reads */

`timescale 1ns/1ns
`default_nettype none

`include "sched_cfg.svh"

module enqueue_wb_slave (
    input  wire                        core_clk_ifc,
    input  wire                        rst_n,
    input  wire                        wb_cyc,
    input  wire                        wb_stb,
    input  wire                        wb_we,
    input  wire                        wb_adr,
    input  wire  [`SCHED_WB_DW-1:0]    wb_dat_w,
    input  sched_pkg::queue_mask_t     queue_full,
    input  sched_pkg::queue_mask_t     queue_empty,
    output logic [`SCHED_WB_DW-1:0]    wb_dat_r,
    output logic                       wb_ack,
    output logic                       wb_err,
    output logic                       push,
    output sched_pkg::queue_id_t       push_queue,
    output sched_pkg::pkt_len_t        push_len
);

    logic                 req;
    logic                 enq_wr;
    logic                 enq_full;
    sched_pkg::queue_id_t enq_queue;

    // New request only once the previous reply has gone low
    assign req       = wb_cyc & wb_stb & ~wb_ack & ~wb_err;
    assign enq_wr    = req & wb_we & (wb_adr == 1'b0);
    assign enq_queue = sched_pkg::queue_id_t'(wb_dat_w[`SCHED_QUEUE_W-1:0]);
    assign enq_full  = queue_full[enq_queue];

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
            push   <= 1'b0;
        end else begin
            wb_ack <= req & ~(enq_wr & enq_full);
            wb_err <= enq_wr & enq_full;
            push   <= enq_wr & ~enq_full;
        end
    end

    // Descriptor fields and read data follow the request
    always_ff @(posedge core_clk_ifc) begin
        push_queue <= enq_queue;
        push_len   <= wb_dat_w[`SCHED_LEN_LSB +: `SCHED_LEN_W];
        if (req && !wb_we && wb_adr) begin
            wb_dat_r <= {{(`SCHED_WB_DW - `SCHED_NUM_QUEUES){1'b0}}, queue_empty};
        end else begin
            wb_dat_r <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pkt_len_queues.sv ====
/* Sixteen circular length FIFOs with push, pop, head read and empty/full flags */

`timescale 1ns/1ns
`default_nettype none

`include "sched_cfg.svh"

module pkt_len_queues (
    input  wire                     core_clk_ifc,
    input  wire                     rst_n,
    input  wire                     push,
    input  sched_pkg::queue_id_t    push_queue,
    input  sched_pkg::pkt_len_t     push_len,
    input  wire                     pop,
    input  sched_pkg::queue_id_t    pop_queue,
    output sched_pkg::queue_mask_t  queue_empty,
    output sched_pkg::queue_mask_t  queue_full,
    output sched_pkg::pkt_len_t     head_len
);

    sched_pkg::pkt_len_t      mem    [`SCHED_NUM_QUEUES][`SCHED_FIFO_DEPTH];
    logic [`SCHED_PTR_W-1:0]  rd_ptr [`SCHED_NUM_QUEUES];
    logic [`SCHED_PTR_W-1:0]  wr_ptr [`SCHED_NUM_QUEUES];
    logic [`SCHED_CNT_W-1:0]  count  [`SCHED_NUM_QUEUES];

    logic do_push;
    logic do_pop;

    assign do_push = push & ~queue_full[push_queue];
    assign do_pop  = pop & ~queue_empty[pop_queue];

    always_comb begin
        for (int q = 0; q < `SCHED_NUM_QUEUES; q++) begin
            queue_empty[q] = (count[q] == '0);
            queue_full[q]  = (count[q] == `SCHED_CNT_W'(`SCHED_FIFO_DEPTH));
        end
    end

    // Head of the queue being popped, read without a register
    assign head_len = mem[pop_queue][rd_ptr[pop_queue]];

    always_ff @(posedge core_clk_ifc) begin
        if (do_push) begin
            mem[push_queue][wr_ptr[push_queue]] <= push_len;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < `SCHED_NUM_QUEUES; q++) begin
                rd_ptr[q] <= '0;
                wr_ptr[q] <= '0;
                count[q]  <= '0;
            end
        end else begin
            for (int q = 0; q < `SCHED_NUM_QUEUES; q++) begin
                if (do_push && push_queue == sched_pkg::queue_id_t'(q)) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (do_pop && pop_queue == sched_pkg::queue_id_t'(q)) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                // Push and pop on the same queue leave the count as it is
                case ({do_push && push_queue == sched_pkg::queue_id_t'(q),
                       do_pop && pop_queue == sched_pkg::queue_id_t'(q)})
                    2'b10:   count[q] <= count[q] + 1'b1;
                    2'b01:   count[q] <= count[q] - 1'b1;
                    default: count[q] <= count[q];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== scheduler/port_arbiter.sv ====
/* Stage 1: round-robin grant of an egress port with queued work, ready and idle */

`timescale 1ns/1ns
`default_nettype none

`include "sched_cfg.svh"

module port_arbiter (
    input  wire                     core_clk_ifc,
    input  wire                     rst_n,
    input  sched_pkg::queue_mask_t  queue_empty,
    input  sched_pkg::port_mask_t   egr_ready,
    input  sched_pkg::port_mask_t   seg_busy_ports,
    input  wire                     stage_full,
    output logic                    grant_valid,
    output sched_pkg::port_id_t     grant_port
);

    sched_pkg::port_mask_t eligible;
    sched_pkg::port_id_t   rr_ptr;
    sched_pkg::port_id_t   pick;
    sched_pkg::port_id_t   cand;
    logic                  pick_valid;

    // Any queue of the port holds a descriptor
    for (genvar p = 0; p < `SCHED_NUM_PORTS; p++) begin : g_elig
        assign eligible[p] = ~(&queue_empty[p*`SCHED_PRIOS +: `SCHED_PRIOS])
                           & egr_ready[p] & ~seg_busy_ports[p];
    end

    // Search from rr_ptr upward, the nearest eligible port wins
    always_comb begin
        pick_valid = 1'b0;
        pick       = rr_ptr;
        cand       = rr_ptr;
        for (int i = `SCHED_NUM_PORTS - 1; i >= 0; i--) begin
            cand = rr_ptr + sched_pkg::port_id_t'(i);
            if (eligible[cand]) begin
                pick_valid = 1'b1;
                pick       = cand;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant register

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            grant_valid <= 1'b0;
            grant_port  <= '0;
            rr_ptr      <= '0;
        end else begin
            grant_valid <= 1'b0;
            // One grant in flight at a time, busy bit shows from the next cycle
            if (pick_valid && !grant_valid && !stage_full) begin
                grant_valid <= 1'b1;
                grant_port  <= pick;
                rr_ptr      <= pick + sched_pkg::port_id_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== scheduler/prio_select.sv ====
/* Stage 2: strict-priority pick of the highest non-empty queue of the granted port */

`timescale 1ns/1ns
`default_nettype none

`include "sched_cfg.svh"

module prio_select (
    input  wire                     core_clk_ifc,
    input  wire                     rst_n,
    input  wire                     grant_valid,
    input  sched_pkg::port_id_t     grant_port,
    input  sched_pkg::queue_mask_t  queue_empty,
    output logic                    sel_valid,
    output sched_pkg::queue_id_t    sel_queue
);

    sched_pkg::prio_t best_prio;

    // Ascending scan, so the last hit is the highest priority
    always_comb begin
        best_prio = '0;
        for (int i = 0; i < `SCHED_PRIOS; i++) begin
            if (!queue_empty[{grant_port, sched_pkg::prio_t'(i)}]) begin
                best_prio = sched_pkg::prio_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Selection register

    // The port was granted with work queued and stays busy until its packet
    // ends, so the grant always finds a non-empty queue here
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= grant_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (grant_valid) begin
            sel_queue <= {grant_port, best_prio};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/word_segmenter.sv ====
/* Stage 3: pops the selected packet, emits its bus-word notifications, tracks busy ports */

`timescale 1ns/1ns
`default_nettype none

`include "sched_cfg.svh"

module word_segmenter (
    input  wire                     core_clk_ifc,
    input  wire                     rst_n,
    input  wire                     grant_valid,
    input  sched_pkg::port_id_t     grant_port,
    input  wire                     sel_valid,
    input  sched_pkg::queue_id_t    sel_queue,
    input  sched_pkg::pkt_len_t     head_len,
    input  sched_pkg::port_mask_t   egr_ready,
    output logic                    pop,
    output sched_pkg::queue_id_t    pop_queue,
    output sched_pkg::port_mask_t   seg_busy_ports,
    output logic                    stage_full,
    output logic                    notif_valid,
    output sched_pkg::queue_id_t    notif_queue,
    output sched_pkg::word_bytes_t  notif_bytes,
    output logic                    notif_last
);

    sched_pkg::seg_state_t state;
    sched_pkg::port_mask_t busy_q;
    sched_pkg::queue_id_t  hold_queue;
    sched_pkg::queue_id_t  cur_queue;
    sched_pkg::port_id_t   cur_port;
    sched_pkg::pkt_len_t   remain;
    logic                  hold_valid;
    logic                  last_word;

    assign cur_port  = cur_queue[`SCHED_QUEUE_W-1 -: `SCHED_PORT_W];
    assign last_word = (remain <= sched_pkg::pkt_len_t'(`SCHED_WORD_BYTES));

    // Start the held packet as soon as the FSM is idle
    assign pop            = (state == sched_pkg::seg_idle) & hold_valid;
    assign pop_queue      = hold_queue;
    assign stage_full     = hold_valid | sel_valid;
    assign seg_busy_ports = busy_q;

    // Words follow the port's ready in the same cycle
    assign notif_valid = (state == sched_pkg::seg_send) & egr_ready[cur_port];
    assign notif_queue = cur_queue;
    assign notif_bytes = last_word ? sched_pkg::word_bytes_t'(remain)
                                   : sched_pkg::word_bytes_t'(`SCHED_WORD_BYTES);
    assign notif_last  = notif_valid & last_word;

    ////////////////////////////////////////////////////////////////////////////
    // FSM, holding register and busy ports

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state      <= sched_pkg::seg_idle;
            hold_valid <= 1'b0;
            busy_q     <= '0;
        end else begin
            case (state)
                sched_pkg::seg_idle: if (hold_valid) state <= sched_pkg::seg_send;
                sched_pkg::seg_send: if (notif_last) state <= sched_pkg::seg_idle;
                default:             state <= sched_pkg::seg_idle;
            endcase
            if (sel_valid) begin
                hold_valid <= 1'b1;
            end else if (pop) begin
                hold_valid <= 1'b0;
            end
            if (notif_last) begin
                busy_q[cur_port] <= 1'b0;
            end
            if (grant_valid) begin
                busy_q[grant_port] <= 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (sel_valid) begin
            hold_queue <= sel_queue;
        end
        if (pop) begin
            cur_queue <= hold_queue;
            remain    <= head_len;
        end else if (notif_valid && !last_word) begin
            remain <= remain - sched_pkg::pkt_len_t'(`SCHED_WORD_BYTES);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pkt_sched_top.sv ====
/* Scheduler top: Wishbone enqueue slave, length FIFOs and the three pipeline stages */

`timescale 1ns/1ns
`default_nettype none

`include "sched_cfg.svh"

module pkt_sched_top (
    input  wire                     core_clk_ifc,
    input  wire                     rst_n,
    input  wire                     wb_cyc,
    input  wire                     wb_stb,
    input  wire                     wb_we,
    input  wire                     wb_adr,
    input  wire  [`SCHED_WB_DW-1:0] wb_dat_w,
    output logic [`SCHED_WB_DW-1:0] wb_dat_r,
    output logic                    wb_ack,
    output logic                    wb_err,
    input  sched_pkg::port_mask_t   egr_ready,
    output logic                    notif_valid,
    output sched_pkg::queue_id_t    notif_queue,
    output sched_pkg::word_bytes_t  notif_bytes,
    output logic                    notif_last
);

    // Enqueue path
    logic                   push;
    sched_pkg::queue_id_t   push_queue;
    sched_pkg::pkt_len_t    push_len;
    sched_pkg::queue_mask_t queue_full;
    sched_pkg::queue_mask_t queue_empty;

    // Dequeue path
    logic                   pop;
    sched_pkg::queue_id_t   pop_queue;
    sched_pkg::pkt_len_t    head_len;

    // Pipeline between the stages
    logic                   grant_valid;
    sched_pkg::port_id_t    grant_port;
    logic                   sel_valid;
    sched_pkg::queue_id_t   sel_queue;
    sched_pkg::port_mask_t  seg_busy_ports;
    logic                   stage_full;

    enqueue_wb_slave enq_slave_i (
        .core_clk_ifc (core_clk_ifc), .rst_n       (rst_n),
        .wb_cyc       (wb_cyc),       .wb_stb      (wb_stb),
        .wb_we        (wb_we),        .wb_adr      (wb_adr),
        .wb_dat_w     (wb_dat_w),     .queue_full  (queue_full),
        .queue_empty  (queue_empty),  .wb_dat_r    (wb_dat_r),
        .wb_ack       (wb_ack),       .wb_err      (wb_err),
        .push         (push),         .push_queue  (push_queue),
        .push_len     (push_len)
    );

    pkt_len_queues queues_i (
        .core_clk_ifc (core_clk_ifc), .rst_n       (rst_n),
        .push         (push),         .push_queue  (push_queue),
        .push_len     (push_len),     .pop         (pop),
        .pop_queue    (pop_queue),    .queue_empty (queue_empty),
        .queue_full   (queue_full),   .head_len    (head_len)
    );

    port_arbiter arbiter_i (
        .core_clk_ifc   (core_clk_ifc),   .rst_n       (rst_n),
        .queue_empty    (queue_empty),    .egr_ready   (egr_ready),
        .seg_busy_ports (seg_busy_ports), .stage_full  (stage_full),
        .grant_valid    (grant_valid),    .grant_port  (grant_port)
    );

    prio_select prio_i (
        .core_clk_ifc (core_clk_ifc), .rst_n       (rst_n),
        .grant_valid  (grant_valid),  .grant_port  (grant_port),
        .queue_empty  (queue_empty),  .sel_valid   (sel_valid),
        .sel_queue    (sel_queue)
    );

    word_segmenter segmenter_i (
        .core_clk_ifc   (core_clk_ifc),   .rst_n       (rst_n),
        .grant_valid    (grant_valid),    .grant_port  (grant_port),
        .sel_valid      (sel_valid),      .sel_queue   (sel_queue),
        .head_len       (head_len),       .egr_ready   (egr_ready),
        .pop            (pop),            .pop_queue   (pop_queue),
        .seg_busy_ports (seg_busy_ports), .stage_full  (stage_full),
        .notif_valid    (notif_valid),    .notif_queue (notif_queue),
        .notif_bytes    (notif_bytes),    .notif_last  (notif_last)
    );

endmodule

`default_nettype wire

// ==== verif/pkt_sched_properties.sv ====
/* Bound assertions on the scheduler top: ready gating, word byte range, Wishbone reply, reset */

`timescale 1ns/1ns
`default_nettype none

`include "sched_cfg.svh"

module pkt_sched_properties (
    input  wire                     core_clk_ifc,
    input  wire                     rst_n,
    input  wire                     wb_ack,
    input  wire                     wb_err,
    input  sched_pkg::port_mask_t   egr_ready,
    input  wire                     notif_valid,
    input  sched_pkg::queue_id_t    notif_queue,
    input  sched_pkg::word_bytes_t  notif_bytes
);

    // A word only goes out on a port that is ready in the same cycle
    a_word_needs_ready: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        notif_valid |-> egr_ready[notif_queue[`SCHED_QUEUE_W-1 -: `SCHED_PORT_W]])
        else $error("notification on a port whose egr_ready is low");

    a_word_bytes_range: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        notif_valid |-> (notif_bytes >= sched_pkg::word_bytes_t'(1)
                     && notif_bytes <= sched_pkg::word_bytes_t'(`SCHED_WORD_BYTES)))
        else $error("notif_bytes outside 1 to 64");

    // One reply per request, never both kinds
    a_ack_err_exclusive: assert property (@(posedge core_clk_ifc) !(wb_ack && wb_err))
        else $error("wb_ack and wb_err high together");

    a_quiet_in_reset: assert property (@(posedge core_clk_ifc) !rst_n |-> !notif_valid)
        else $error("notif_valid high during reset");

endmodule

`default_nettype wire

// ==== verif/pkt_sched_tb.sv ====
/* Testbench for the egress scheduler: clock, reset, random enqueue batches,
   per-queue length model, word and status checks */

`timescale 1ns/1ns
`default_nettype none

`include "sched_cfg.svh"

module pkt_sched_tb;

    logic                    core_clk_ifc;
    logic                    rst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic                    wb_adr;
    logic [`SCHED_WB_DW-1:0] wb_dat_w;
    logic [`SCHED_WB_DW-1:0] wb_dat_r;
    logic                    wb_ack;
    logic                    wb_err;
    sched_pkg::port_mask_t   egr_ready;
    logic                    notif_valid;
    sched_pkg::queue_id_t    notif_queue;
    sched_pkg::word_bytes_t  notif_bytes;
    logic                    notif_last;

    // Model of the queued lengths per queue and of the packet being segmented
    int   model_len [`SCHED_NUM_QUEUES][$];
    logic in_pkt;
    int   cur_queue;
    int   remain;

    int seed;
    int errors;
    int words_seen;
    int pkts_seen;
    int batch_bytes;
    int batch_pkts;
    int cycles = 0;
    int cycle_limit = 1000;

    pkt_sched_top dut_i (
        .core_clk_ifc (core_clk_ifc), .rst_n       (rst_n),
        .wb_cyc       (wb_cyc),       .wb_stb      (wb_stb),
        .wb_we        (wb_we),        .wb_adr      (wb_adr),
        .wb_dat_w     (wb_dat_w),     .wb_dat_r    (wb_dat_r),
        .wb_ack       (wb_ack),       .wb_err      (wb_err),
        .egr_ready    (egr_ready),    .notif_valid (notif_valid),
        .notif_queue  (notif_queue),  .notif_bytes (notif_bytes),
        .notif_last   (notif_last)
    );

    bind pkt_sched_top pkt_sched_properties props_i (
        .core_clk_ifc (core_clk_ifc), .rst_n       (rst_n),
        .wb_ack       (wb_ack),       .wb_err      (wb_err),
        .egr_ready    (egr_ready),    .notif_valid (notif_valid),
        .notif_queue  (notif_queue),  .notif_bytes (notif_bytes)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    // Watchdog whose limit moves with each phase
    initial begin
        while (cycles < cycle_limit) begin
            @(posedge core_clk_ifc);
            cycles = cycles + 1;
        end
        $display("Timeout after %0d cycles, the scheduler stopped making progress", cycles);
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Model helpers

    function automatic int model_count();
        int total;
        begin
            total = 0;
            for (int q = 0; q < `SCHED_NUM_QUEUES; q++) begin
                total = total + model_len[q].size();
            end
            model_count = total;
        end
    endfunction

    // Highest non-empty queue of a port or -1 if it has none
    function automatic int highest_queue(input int port);
        int result;
        begin
            result = -1;
            for (int p = 0; p < `SCHED_PRIOS; p++) begin
                if (model_len[port * `SCHED_PRIOS + p].size() != 0) begin
                    result = port * `SCHED_PRIOS + p;
                end
            end
            highest_queue = result;
        end
    endfunction

    task automatic allow_cycles(input int extra);
        begin
            cycle_limit = cycles + extra;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Notification checks

    task automatic check_word;
        int   port;
        int   exp_queue;
        int   exp_bytes;
        logic exp_last;
        begin
            port = int'(notif_queue) / `SCHED_PRIOS;
            words_seen++;
            if (!egr_ready[port]) begin
                $display("Error at %0t: egr_ready[%0d] expected 1 got 0", $time, port);
                errors++;
            end
            if (!in_pkt) begin
                exp_queue = highest_queue(port);
                if (exp_queue < 0) begin
                    $display("Word for queue %0d at %0t, but no packet is queued on port %0d",
                             notif_queue, $time, port);
                    errors++;
                end else begin
                    if (int'(notif_queue) != exp_queue) begin
                        $display("Error at %0t: notif_queue expected %0d got %0d",
                                 $time, exp_queue, notif_queue);
                        errors++;
                    end
                    cur_queue = exp_queue;
                    remain    = model_len[exp_queue].pop_front();
                    in_pkt    = 1'b1;
                    pkts_seen++;
                end
            end else if (int'(notif_queue) != cur_queue) begin
                // Another queue broke into the packet
                $display("Error at %0t: notif_queue expected %0d got %0d",
                         $time, cur_queue, notif_queue);
                errors++;
            end
            if (in_pkt) begin
                exp_bytes = (remain > `SCHED_WORD_BYTES) ? `SCHED_WORD_BYTES : remain;
                exp_last  = (remain <= `SCHED_WORD_BYTES);
                if (int'(notif_bytes) != exp_bytes) begin
                    $display("Error at %0t: notif_bytes expected %0d got %0d",
                             $time, exp_bytes, notif_bytes);
                    errors++;
                end
                if (notif_last !== exp_last) begin
                    $display("Error at %0t: notif_last expected %0b got %0b",
                             $time, exp_last, notif_last);
                    errors++;
                end
                remain = remain - exp_bytes;
                if (remain == 0) begin
                    in_pkt = 1'b0;
                end
            end
        end
    endtask

    // Word and reply checks on the falling edge
    always @(negedge core_clk_ifc) begin
        if (!rst_n && notif_valid) begin
            $display("Error at %0t: notif_valid expected 0 got 1", $time);
            errors++;
        end
        if (rst_n && wb_ack && wb_err) begin
            $display("Error at %0t: wb_ack and wb_err both high", $time);
            errors++;
        end
        if (rst_n && notif_last && !notif_valid) begin
            $display("Error at %0t: notif_last expected 0 got 1", $time);
            errors++;
        end
        if (rst_n && notif_valid) begin
            check_word();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone master

    task automatic wb_access(input logic we, input logic adr, input logic [31:0] data,
                             output logic ack, output logic err, output logic [31:0] rdata);
        int waited;
        begin
            @(posedge core_clk_ifc);
            #1;
            wb_cyc   = 1'b1;
            wb_stb   = 1'b1;
            wb_we    = we;
            wb_adr   = adr;
            wb_dat_w = data;
            waited   = 0;
            @(negedge core_clk_ifc);
            while (!wb_ack && !wb_err && waited < 8) begin
                @(negedge core_clk_ifc);
                waited++;
            end
            ack   = wb_ack;
            err   = wb_err;
            rdata = wb_dat_r;
            @(posedge core_clk_ifc);
            #1;
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            if (!ack && !err) begin
                $display("Wishbone request at %0t got neither ack nor err", $time);
                errors++;
            end
        end
    endtask

    task automatic enqueue(input int q, input int len);
        logic        ack;
        logic        err;
        logic        exp_err;
        logic [31:0] data;
        logic [31:0] rdata;
        begin
            exp_err = (model_len[q].size() == `SCHED_FIFO_DEPTH);
            data    = '0;
            data[`SCHED_QUEUE_W-1:0]               = q[`SCHED_QUEUE_W-1:0];
            data[`SCHED_LEN_LSB +: `SCHED_LEN_W]   = len[`SCHED_LEN_W-1:0];
            wb_access(1'b1, 1'b0, data, ack, err, rdata);
            if (err !== exp_err) begin
                $display("Error at %0t: wb_err expected %0b got %0b", $time, exp_err, err);
                errors++;
            end
            if (ack !== !exp_err) begin
                $display("Error at %0t: wb_ack expected %0b got %0b", $time, !exp_err, ack);
                errors++;
            end
            if (!exp_err) begin
                model_len[q].push_back(len);
                batch_bytes = batch_bytes + len;
                batch_pkts++;
            end
        end
    endtask

    task automatic enqueue_batch(input int count);
        int q;
        int len;
        begin
            for (int i = 0; i < count; i++) begin
                q   = $unsigned($random(seed)) % `SCHED_NUM_QUEUES;
                len = 1 + $unsigned($random(seed)) % 1500;
                enqueue(q, len);
            end
        end
    endtask

    // Eight descriptors fit and the ninth comes back with err
    task automatic overfill_queue;
        int q;
        begin
            q = $unsigned($random(seed)) % `SCHED_NUM_QUEUES;
            for (int i = 0; i <= `SCHED_FIFO_DEPTH; i++) begin
                enqueue(q, 1 + $unsigned($random(seed)) % 1500);
            end
        end
    endtask

    task automatic check_status;
        logic                   ack;
        logic                   err;
        logic [31:0]            rdata;
        sched_pkg::queue_mask_t exp_empty;
        begin
            for (int q = 0; q < `SCHED_NUM_QUEUES; q++) begin
                exp_empty[q] = (model_len[q].size() == 0);
            end
            wb_access(1'b0, 1'b1, '0, ack, err, rdata);
            if (!ack) begin
                $display("Error at %0t: wb_ack expected 1 got %0b", $time, ack);
                errors++;
            end
            if (rdata[`SCHED_NUM_QUEUES-1:0] !== exp_empty) begin
                $display("Error at %0t: wb_dat_r expected %h got %h",
                         $time, exp_empty, rdata[`SCHED_NUM_QUEUES-1:0]);
                errors++;
            end
        end
    endtask

    task automatic drain;
        logic [31:0] rnd;
        begin
            allow_cycles((batch_bytes / `SCHED_WORD_BYTES) * 4 + batch_pkts * 16 + 200);
            batch_bytes = 0;
            batch_pkts  = 0;
            while (model_count() != 0 || in_pkt) begin
                @(posedge core_clk_ifc);
                #1;
                rnd       = $random(seed);
                egr_ready = rnd[`SCHED_NUM_PORTS-1:0];
            end
            @(posedge core_clk_ifc);
            #1;
            egr_ready = '0;
            repeat (8) @(posedge core_clk_ifc);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 1'b0;
        wb_dat_w    = '0;
        egr_ready   = '0;
        seed        = 32'he832;
        errors      = 0;
        words_seen  = 0;
        pkts_seen   = 0;
        batch_bytes = 0;
        batch_pkts  = 0;
        in_pkt      = 1'b0;
        cur_queue   = 0;
        remain      = 0;
        repeat (16) @(posedge core_clk_ifc);
        #1;
        rst_n = 1'b1;

        // First batch waits behind egr_ready low
        allow_cycles(40 * 8 + 200);
        check_status();
        enqueue_batch(24);
        check_status();
        drain();
        allow_cycles(40 * 8 + 200);
        check_status();

        // Full queue and then a second batch on top
        overfill_queue();
        enqueue_batch(24);
        check_status();
        drain();
        allow_cycles(100);
        check_status();

        if (model_count() != 0 || in_pkt) begin
            $display("%0d packets were never emitted", model_count());
            errors++;
        end
        $display("Checks done: %0d packets, %0d words, %0d errors",
                 pkts_seen, words_seen, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/sched_pkg.sv
rtl/enqueue_wb_slave.sv
rtl/pkt_len_queues.sv
scheduler/port_arbiter.sv
scheduler/prio_select.sv
rtl/word_segmenter.sv
rtl/pkt_sched_top.sv
verif/pkt_sched_properties.sv
verif/pkt_sched_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the egress scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module pkt_sched_tb \
    -Mdir obj_dir \
    -o pkt_sched_sim

./obj_dir/pkt_sched_sim | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation did not pass, see sim.log"
    exit 1
fi
